// ==== Bender.yml ====
package:
  name: character_core

sources:
  - include_dirs:
      - design
    files:
      - design/character_pkg.sv
      - design/button_sampler.sv
      - design/motion_fsm.sv
      - design/physics_integrator.sv
      - design/wall_detector.sv
      - design/character_core.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_character.sv

// ==== design/button_sampler.sv ====
//--------------------------------------------------------------------------
// Input stage of the character core. Registers the game-step strobe and
// the three button levels, and flags the rising edge of the jump button.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module button_sampler (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic char_tick,
    input  logic left_btn,
    input  logic right_btn,
    input  logic jump_btn,
    output logic step,
    output logic left_lvl,
    output logic right_lvl,
    output logic jump_lvl,
    output logic jump_press
);

    logic jump_lvl_d;   // previous registered jump level

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step       <= 1'b0;
            left_lvl   <= 1'b0;
            right_lvl  <= 1'b0;
            jump_lvl   <= 1'b0;
            jump_lvl_d <= 1'b0;
        end else begin
            step       <= char_tick;
            left_lvl   <= left_btn;
            right_lvl  <= right_btn;
            jump_lvl   <= jump_btn;
            jump_lvl_d <= jump_lvl;
        end
    end

    // one cycle high on a new press
    assign jump_press = jump_lvl & ~jump_lvl_d;

endmodule

// ==== design/character_cfg.svh ====
//--------------------------------------------------------------------------
// Build-time constants for the character motion core: arena bounds,
// character size, fixed-point speeds and jump charging.
// Velocities carry CHAR_SMOOTH fraction bits, positions are whole pixels.
//--------------------------------------------------------------------------
`ifndef CHARACTER_CFG_SVH
`define CHARACTER_CFG_SVH

`define CHAR_COORD_W      15    // signed coordinate / velocity width
`define CHAR_SMOOTH       7     // fraction bits of a velocity

// character box
`define CHAR_WIDTH_X      32
`define CHAR_WIDTH_Y      32

// arena, inner wall edges
`define CHAR_X_MIN        160
`define CHAR_X_MAX        560
`define CHAR_FLOOR_Y      20
`define CHAR_INIT_X       300
`define CHAR_INIT_Y       20    // standing on the floor

// speeds
`define CHAR_WALK_STEP    3                       // whole pixels per step
`define CHAR_GRAVITY      (1 << `CHAR_SMOOTH)
`define CHAR_MAX_VEL      (40 << `CHAR_SMOOTH)
`define CHAR_JUMP_VEL_X   (1 << `CHAR_SMOOTH)
`define CHAR_JUMP_VEL_Y   (3 << `CHAR_SMOOTH)

// jump charging
`define CHAR_MAX_CHARGE   100
`define CHAR_CHARGE_INC   5
`define CHAR_CHARGE_SHIFT 4     // count to jump velocity scale

`endif

// ==== design/character_core.sv ====
//--------------------------------------------------------------------------
// Top of the character motion core. Chains input sampling, the movement
// FSM, the physics update and wall detection; collision and on-ground
// flags loop back from the last stage. Issue char_tick once per game step.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module character_core (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       char_tick,
    input  logic                       left_btn,
    input  logic                       right_btn,
    input  logic                       jump_btn,
    output character_pkg::coord_t      pos_x,
    output character_pkg::coord_t      pos_y,
    output character_pkg::coord_t      vel_x,
    output character_pkg::coord_t      vel_y,
    output character_pkg::char_state_e state,
    output character_pkg::face_t       face,
    output logic                       on_ground
);

    import character_pkg::*;

    logic       step;
    logic       left_lvl;
    logic       right_lvl;
    logic       jump_lvl;
    logic       jump_press;
    coord_t     jump_factor;
    collision_e collision;      // fed back from the wall stage

    button_sampler button_sampler_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .char_tick  (char_tick),
        .left_btn   (left_btn),
        .right_btn  (right_btn),
        .jump_btn   (jump_btn),
        .step       (step),
        .left_lvl   (left_lvl),
        .right_lvl  (right_lvl),
        .jump_lvl   (jump_lvl),
        .jump_press (jump_press)
    );

    motion_fsm motion_fsm_i (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .step        (step),
        .left_lvl    (left_lvl),
        .right_lvl   (right_lvl),
        .jump_lvl    (jump_lvl),
        .jump_press  (jump_press),
        .collision   (collision),
        .on_ground   (on_ground),
        .state       (state),
        .face        (face),
        .jump_factor (jump_factor)
    );

    physics_integrator physics_integrator_i (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .step        (step),
        .state       (state),
        .face        (face),
        .jump_factor (jump_factor),
        .collision   (collision),
        .on_ground   (on_ground),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .vel_x       (vel_x),
        .vel_y       (vel_y)
    );

    wall_detector wall_detector_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .collision (collision),
        .on_ground (on_ground)
    );

endmodule

// ==== design/character_pkg.sv ====
//--------------------------------------------------------------------------
// Types shared by the character motion stages: coordinates, movement
// state, collision class and facing direction.
//--------------------------------------------------------------------------
`include "character_cfg.svh"

package character_pkg;

    // position and velocity word, two's complement
    typedef logic signed [`CHAR_COORD_W-1:0] coord_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LEFT      = 3'd1,
        ST_RIGHT     = 3'd2,
        ST_CHARGE    = 3'd3,
        ST_JUMP      = 3'd4,
        ST_COLLISION = 3'd5
    } char_state_e;

    typedef enum logic [1:0] {
        COL_NONE       = 2'd0,
        COL_VERTICAL   = 2'd1,   // floor hit
        COL_HORIZONTAL = 2'd2    // side wall hit
    } collision_e;

    // +1 faces left (increasing x), -1 faces right
    typedef logic signed [1:0] face_t;

endpackage

// ==== design/motion_fsm.sv ====
//--------------------------------------------------------------------------
// Movement FSM of the character. Advances once per game step, keeps the
// jump charge count and the facing direction, and hands the charge to
// the physics stage as a jump velocity term.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "character_cfg.svh"

module motion_fsm (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic                      step,
    input  logic                      left_lvl,
    input  logic                      right_lvl,
    input  logic                      jump_lvl,
    input  logic                      jump_press,
    input  character_pkg::collision_e collision,
    input  logic                      on_ground,
    output character_pkg::char_state_e state,
    output character_pkg::face_t      face,
    output character_pkg::coord_t     jump_factor
);

    import character_pkg::*;

    // count range covers one increment past the limit
    localparam int CNT_W = $clog2(`CHAR_MAX_CHARGE + 2 * `CHAR_CHARGE_INC);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`CHAR_MAX_CHARGE);
    localparam logic [CNT_W-1:0] CNT_INC = CNT_W'(`CHAR_CHARGE_INC);

    char_state_e      next_state;
    logic [CNT_W-1:0] charge_cnt;
    logic             jump_pending;     // press seen while standing

    //----------------------------------------------------------------------
    // jump request latch, runs every cycle since the press is one cycle
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_pending <= 1'b0;
        end else if (jump_press && on_ground) begin
            jump_pending <= 1'b1;
        end else if (state == ST_JUMP) begin
            jump_pending <= 1'b0;
        end
    end

    //----------------------------------------------------------------------
    // next state
    //----------------------------------------------------------------------
    always_comb begin
        next_state = ST_IDLE;
        if (collision != COL_NONE) begin
            next_state = ST_COLLISION;
        end else begin
            case (state)
                ST_IDLE, ST_LEFT, ST_RIGHT: begin
                    if (!on_ground) begin
                        next_state = ST_IDLE;           // airborne, no control
                    end else if (left_lvl) begin
                        next_state = ST_LEFT;
                    end else if (right_lvl) begin
                        next_state = ST_RIGHT;
                    end else if (jump_pending) begin
                        next_state = ST_CHARGE;
                    end
                end
                ST_CHARGE: begin
                    if (!jump_lvl || charge_cnt >= CNT_MAX) begin
                        next_state = ST_JUMP;
                    end else begin
                        next_state = ST_CHARGE;
                    end
                end
                default: next_state = ST_IDLE;          // jump, collision
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= ST_IDLE;
            charge_cnt <= CNT_W'(1);
            face       <= 2'sd1;
        end else if (step) begin
            state <= next_state;

            if (state == ST_CHARGE) begin
                charge_cnt <= charge_cnt + CNT_INC;
            end else if (state == ST_JUMP) begin
                charge_cnt <= CNT_W'(1);
            end

            if (collision == COL_HORIZONTAL) begin
                face <= -face;                          // bounce turns around
            end else if (state == ST_LEFT) begin
                face <= 2'sd1;
            end else if (state == ST_RIGHT) begin
                face <= -2'sd1;
            end
        end
    end

    // linear in the count
    assign jump_factor = coord_t'(charge_cnt) <<< `CHAR_CHARGE_SHIFT;

endmodule

// ==== design/physics_integrator.sv ====
//--------------------------------------------------------------------------
// Physics stage. On each game step applies gravity, bounce damping and
// the jump impulse to the velocity, saturates it, then moves the
// character by its walking step and its integer velocity inside the arena.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "character_cfg.svh"

module physics_integrator (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       step,
    input  character_pkg::char_state_e state,
    input  character_pkg::face_t       face,
    input  character_pkg::coord_t      jump_factor,
    input  character_pkg::collision_e  collision,
    input  logic                       on_ground,
    output character_pkg::coord_t      pos_x,
    output character_pkg::coord_t      pos_y,
    output character_pkg::coord_t      vel_x,
    output character_pkg::coord_t      vel_y
);

    import character_pkg::*;

    localparam coord_t GRAVITY = coord_t'(`CHAR_GRAVITY);
    localparam coord_t MAX_VEL = coord_t'(`CHAR_MAX_VEL);
    localparam coord_t JUMP_VX = coord_t'(`CHAR_JUMP_VEL_X);
    localparam coord_t JUMP_VY = coord_t'(`CHAR_JUMP_VEL_Y);
    localparam coord_t WALK    = coord_t'(`CHAR_WALK_STEP);
    localparam coord_t X_LO    = coord_t'(`CHAR_X_MIN);
    localparam coord_t X_HI    = coord_t'(`CHAR_X_MAX - `CHAR_WIDTH_X);
    localparam coord_t Y_LO    = coord_t'(`CHAR_FLOOR_Y);

    coord_t vx_raw, vy_pre, vy_raw;
    coord_t vx_next, vy_next;
    coord_t px_walk, px_clamp, py_clamp;

    function automatic coord_t saturate(input coord_t v);
        if (v >= MAX_VEL) begin
            return MAX_VEL;
        end else if (v < -MAX_VEL) begin
            return -MAX_VEL;
        end
        return v;
    endfunction

    //----------------------------------------------------------------------
    // velocity update
    //----------------------------------------------------------------------
    always_comb begin
        vx_raw = vel_x;
        vy_pre = vel_y;
        if (collision == COL_VERTICAL) begin
            vy_pre = -(vel_y >>> 1);                    // damped floor bounce
        end else if (collision == COL_HORIZONTAL) begin
            vx_raw = -(vel_x >>> 1);
        end else if (state == ST_JUMP) begin
            vx_raw = vel_x + coord_t'(face) * ((JUMP_VX + jump_factor) >>> 1);
            vy_pre = vel_y + JUMP_VY + jump_factor;
        end
        vy_raw  = on_ground ? vy_pre : vy_pre - GRAVITY;
        vx_next = saturate(vx_raw);
        vy_next = saturate(vy_raw);
    end

    //----------------------------------------------------------------------
    // position update, walls first then integer part of velocity
    //----------------------------------------------------------------------
    always_comb begin
        case (state)
            ST_LEFT:  px_walk = pos_x + WALK;
            ST_RIGHT: px_walk = pos_x - WALK;
            default:  px_walk = pos_x;
        endcase
        if (px_walk > X_HI) begin
            px_clamp = X_HI;
        end else if (px_walk < X_LO) begin
            px_clamp = X_LO;
        end else begin
            px_clamp = px_walk;
        end
        py_clamp = (pos_y < Y_LO) ? Y_LO : pos_y;       // no ceiling
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_x <= '0;
            vel_y <= '0;
            pos_x <= coord_t'(`CHAR_INIT_X);
            pos_y <= coord_t'(`CHAR_INIT_Y);
        end else if (step) begin
            vel_x <= vx_next;
            vel_y <= vy_next;
            pos_x <= px_clamp + (vx_next >>> `CHAR_SMOOTH);
            pos_y <= py_clamp + (vy_next >>> `CHAR_SMOOTH);
        end
    end

endmodule

// ==== design/wall_detector.sv ====
//--------------------------------------------------------------------------
// Collision stage. Classifies the current position against the floor and
// the two side walls every cycle, and flags a character standing exactly
// on the floor. Results go back to the FSM and the physics stage.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "character_cfg.svh"

module wall_detector (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  character_pkg::coord_t     pos_x,
    input  character_pkg::coord_t     pos_y,
    output character_pkg::collision_e collision,
    output logic                      on_ground
);

    import character_pkg::*;

    localparam coord_t X_LO   = coord_t'(`CHAR_X_MIN);
    localparam coord_t X_HI   = coord_t'(`CHAR_X_MAX);
    localparam coord_t FLOOR  = coord_t'(`CHAR_FLOOR_Y);
    localparam coord_t X_SPAN = coord_t'(`CHAR_WIDTH_X - 1);  // left to right edge

    collision_e col_class;
    coord_t     right_edge;

    assign right_edge = pos_x + X_SPAN;

    // floor wins over the side walls
    always_comb begin
        if (pos_y < FLOOR) begin
            col_class = COL_VERTICAL;
        end else if (pos_x < X_LO || right_edge >= X_HI) begin
            col_class = COL_HORIZONTAL;
        end else begin
            col_class = COL_NONE;
        end
    end

    //----------------------------------------------------------------------
    // registered every cycle, not only on a step
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            collision <= COL_NONE;
            on_ground <= 1'b0;
        end else begin
            collision <= col_class;
            on_ground <= (pos_y == FLOOR);
        end
    end

endmodule

// ==== sim/tb_character.sv ====
//--------------------------------------------------------------------------
// Directed testbench for the character motion core. Steps the core with
// char_tick and compares every output against a step model after each
// game step. Covers walking, wall clamps, charge, flight, landing, bounce.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "character_cfg.svh"

module tb_character;

    import character_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int STEP_CYCLES = 8;         // cycles between ticks
    localparam int MAX_STEPS   = 400;       // upper bound over all tests
    localparam int TIMEOUT_NS  = (MAX_STEPS * STEP_CYCLES + 200) * CLK_PERIOD;
    localparam int X_HI        = `CHAR_X_MAX - `CHAR_WIDTH_X;
    localparam int CHARGE_HOLD = 4;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        char_tick;
    logic        left_btn;
    logic        right_btn;
    logic        jump_btn;
    coord_t      pos_x;
    coord_t      pos_y;
    coord_t      vel_x;
    coord_t      vel_y;
    char_state_e state;
    face_t       face;
    logic        on_ground;

    // predicted core state
    int st_m;
    int face_m;
    int cnt_m;
    int vx_m;
    int vy_m;
    int px_m;
    int py_m;
    int col_m;      // collision class seen by the last step
    bit pend_m;

    character_core character_core_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .char_tick (char_tick),
        .left_btn  (left_btn),
        .right_btn (right_btn),
        .jump_btn  (jump_btn),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .vel_x     (vel_x),
        .vel_y     (vel_y),
        .state     (state),
        .face      (face),
        .on_ground (on_ground)
    );

    initial sys_clk = 1'b0;
    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    task automatic check(input logic signed [31:0] got, input logic signed [31:0] exp,
                         input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, msg, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first error");
        end
    endtask

    //----------------------------------------------------------------------
    // step model
    //----------------------------------------------------------------------
    function automatic int classify(input int px, input int py);
        if (py < `CHAR_FLOOR_Y) return COL_VERTICAL;    // floor first
        if (px < `CHAR_X_MIN || px + `CHAR_WIDTH_X - 1 >= `CHAR_X_MAX) return COL_HORIZONTAL;
        return COL_NONE;
    endfunction

    function automatic int saturate_vel(input int v);
        if (v >= `CHAR_MAX_VEL) return `CHAR_MAX_VEL;
        if (v < -`CHAR_MAX_VEL) return -`CHAR_MAX_VEL;
        return v;
    endfunction

    task automatic model_step();
        int nst;
        int jf;
        int vx;
        int vy;
        int px;
        bit og;
        col_m = classify(px_m, py_m);
        og    = (py_m == `CHAR_FLOOR_Y);
        if (col_m != COL_NONE) begin
            nst = ST_COLLISION;
        end else if (st_m == ST_CHARGE) begin
            nst = (!jump_btn || cnt_m >= `CHAR_MAX_CHARGE) ? ST_JUMP : ST_CHARGE;
        end else if (st_m == ST_JUMP || st_m == ST_COLLISION || !og) begin
            nst = ST_IDLE;
        end else if (left_btn) begin
            nst = ST_LEFT;
        end else if (right_btn) begin
            nst = ST_RIGHT;
        end else begin
            nst = pend_m ? ST_CHARGE : ST_IDLE;
        end
        // velocity, from the old state
        jf = cnt_m << `CHAR_CHARGE_SHIFT;
        vx = vx_m;
        vy = vy_m;
        if (col_m == COL_VERTICAL) begin
            vy = -(vy_m >>> 1);
        end else if (col_m == COL_HORIZONTAL) begin
            vx = -(vx_m >>> 1);
        end else if (st_m == ST_JUMP) begin
            vx = vx_m + face_m * ((`CHAR_JUMP_VEL_X + jf) >>> 1);
            vy = vy_m + `CHAR_JUMP_VEL_Y + jf;
        end
        if (!og) vy = vy - `CHAR_GRAVITY;
        vx = saturate_vel(vx);
        vy = saturate_vel(vy);
        // walk, clamp, then integer velocity
        px = px_m;
        if (st_m == ST_LEFT) px = px + `CHAR_WALK_STEP;
        else if (st_m == ST_RIGHT) px = px - `CHAR_WALK_STEP;
        if (px > X_HI) px = X_HI;
        else if (px < `CHAR_X_MIN) px = `CHAR_X_MIN;
        if (py_m < `CHAR_FLOOR_Y) py_m = `CHAR_FLOOR_Y;
        px_m = px + (vx >>> `CHAR_SMOOTH);
        py_m = py_m + (vy >>> `CHAR_SMOOTH);
        vx_m = vx;
        vy_m = vy;
        if (col_m == COL_HORIZONTAL) face_m = -face_m;
        else if (st_m == ST_LEFT) face_m = 1;
        else if (st_m == ST_RIGHT) face_m = -1;
        if (st_m == ST_CHARGE) cnt_m = cnt_m + `CHAR_CHARGE_INC;
        else if (st_m == ST_JUMP) cnt_m = 1;
        if (nst == ST_JUMP) pend_m = 1'b0;      // request consumed
        st_m = nst;
    endtask

    task automatic compare_outputs(input string tag);
        check(state, st_m, {tag, ": state"});
        check(face, face_m, {tag, ": face"});
        check(vel_x, vx_m, {tag, ": vel_x"});
        check(vel_y, vy_m, {tag, ": vel_y"});
        check(pos_x, px_m, {tag, ": pos_x"});
        check(pos_y, py_m, {tag, ": pos_y"});
        check(on_ground, py_m == `CHAR_FLOOR_Y, {tag, ": on_ground"});
    endtask

    //----------------------------------------------------------------------
    // stimulus, all on the falling edge
    //----------------------------------------------------------------------
    task automatic apply_reset();
        @(negedge sys_clk);
        sys_rst_n = 1'b0;
        char_tick = 1'b0;
        left_btn  = 1'b0;
        right_btn = 1'b0;
        jump_btn  = 1'b0;
        repeat (10) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        repeat (3) @(negedge sys_clk);          // first detection done
        st_m   = ST_IDLE;
        face_m = 1;
        cnt_m  = 1;
        vx_m   = 0;
        vy_m   = 0;
        px_m   = `CHAR_INIT_X;
        py_m   = `CHAR_INIT_Y;
        col_m  = COL_NONE;
        pend_m = 1'b0;
    endtask

    task automatic set_buttons(input bit l, input bit r, input bit j);
        bit rose;
        rose = j && !jump_btn;
        @(negedge sys_clk);
        left_btn  = l;
        right_btn = r;
        jump_btn  = j;
        repeat (3) @(negedge sys_clk);          // through sampler and latch
        if (rose && py_m == `CHAR_FLOOR_Y) pend_m = 1'b1;
    endtask

    task automatic run_step(input string tag);
        @(negedge sys_clk);
        char_tick = 1'b1;
        @(negedge sys_clk);
        char_tick = 1'b0;
        repeat (STEP_CYCLES - 2) @(negedge sys_clk);
        model_step();
        compare_outputs(tag);
    endtask

    //----------------------------------------------------------------------
    // directed tests
    //----------------------------------------------------------------------
    task automatic reset_values();
        apply_reset();
        check(state, ST_IDLE, "reset state");
        check(face, 1, "reset face");
        check(vel_x, 0, "reset vel_x");
        check(vel_y, 0, "reset vel_y");
        check(pos_x, `CHAR_INIT_X, "reset pos_x");
        check(pos_y, `CHAR_INIT_Y, "reset pos_y");
        check(on_ground, 1, "on_ground after reset");
    endtask

    task automatic walk_and_clamp();
        apply_reset();
        set_buttons(0, 1, 0);
        repeat (80) run_step("walk right");
        check(pos_x, `CHAR_X_MIN, "x held at low wall");
        check(face, -1, "face walking right");
        set_buttons(1, 0, 0);
        repeat (130) run_step("walk left");
        check(pos_x, X_HI, "x held at high wall");
        check(face, 1, "face walking left");
    endtask

    task automatic charge_and_release();
        apply_reset();
        set_buttons(0, 0, 1);
        run_step("charge entry");
        repeat (CHARGE_HOLD) run_step("charge hold");
        check(state, ST_CHARGE, "state while jump held");
        set_buttons(0, 0, 0);
        run_step("jump release");
        check(state, ST_JUMP, "state after release");
        run_step("jump impulse");
        // one increment per charging step, release step included
        check(vel_y, `CHAR_JUMP_VEL_Y +
              ((1 + `CHAR_CHARGE_INC * (CHARGE_HOLD + 1)) << `CHAR_CHARGE_SHIFT),
              "vel_y after charged jump");
    endtask

    task automatic flight_and_landing();
        int n;
        bit landed;
        n      = 0;
        landed = 1'b0;
        while (!(landed && st_m == ST_IDLE) && n < 30) begin
            run_step("flight");
            if (col_m == COL_VERTICAL) landed = 1'b1;
            n++;
        end
        check(landed, 1, "floor collision after jump");
        check(state, ST_IDLE, "state after landing");
    endtask

    task automatic side_wall_bounce();
        int n;
        bit bounced;
        apply_reset();
        set_buttons(1, 0, 0);
        repeat (80) run_step("walk to wall");
        set_buttons(0, 0, 0);
        run_step("stop at wall");
        set_buttons(0, 0, 1);
        run_step("long charge entry");
        n = 0;
        while (st_m != ST_JUMP && n < 30) begin
            run_step("long charge");
            n++;
        end
        check(state, ST_JUMP, "charge ended at count limit");
        n       = 0;
        bounced = 1'b0;
        while (!bounced && n < 10) begin
            run_step("toward wall");
            if (col_m == COL_HORIZONTAL) bounced = 1'b1;
            n++;
        end
        check(bounced, 1, "side-wall collision");
        check(face, -1, "face after bounce");
        run_step("after bounce");
    endtask

    initial begin
        sys_rst_n = 1'b0;
        char_tick = 1'b0;
        left_btn  = 1'b0;
        right_btn = 1'b0;
        jump_btn  = 1'b0;
        reset_values();
        walk_and_clamp();
        charge_and_release();
        flight_and_landing();
        side_wall_bounce();
        $display("PASS: all tests");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/character_pkg.sv
design/button_sampler.sv
design/motion_fsm.sv
design/physics_integrator.sv
design/wall_detector.sv
design/character_core.sv
sim/tb_character.sv
